// ==== Bender.yml ====
package:
  name: mask_alu

sources:
  - files:
      - logic/mask_alu_pkg.sv
      - logic/mask_operand_if.sv
      - logic/mask_uop_decode.sv
      - logic/mask_logic_unit.sv
      - logic/mask_scan_unit.sv
      - logic/mask_result_merge.sv
      - logic/mask_alu_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/mask_alu_checker.sv
      - verif/mask_alu_tb.sv

// ==== files.f ====
logic/mask_alu_pkg.sv
logic/mask_operand_if.sv
logic/mask_uop_decode.sv
logic/mask_logic_unit.sv
logic/mask_scan_unit.sv
logic/mask_result_merge.sv
logic/mask_alu_top.sv
verif/tb_clock_gen.sv
verif/mask_alu_checker.sv
verif/mask_alu_tb.sv

// ==== logic/mask_alu_pkg.sv ====
package mask_alu_pkg;

  localparam int VLEN         = 128;
  localparam int VL_WIDTH     = 8;
  localparam int VSTART_WIDTH = 7;
  localparam int TAG_WIDTH    = 4;

  localparam logic [2:0] FUNCT3_OPMVV = 3'b010;

  // mask-register logical group
  localparam logic [5:0] FUNCT6_VMANDN = 6'b011000;
  localparam logic [5:0] FUNCT6_VMAND  = 6'b011001;
  localparam logic [5:0] FUNCT6_VMOR   = 6'b011010;
  localparam logic [5:0] FUNCT6_VMXOR  = 6'b011011;
  localparam logic [5:0] FUNCT6_VMORN  = 6'b011100;
  localparam logic [5:0] FUNCT6_VMNAND = 6'b011101;
  localparam logic [5:0] FUNCT6_VMNOR  = 6'b011110;
  localparam logic [5:0] FUNCT6_VMXNOR = 6'b011111;

  // unary groups, sub-op carried in the vs1 field
  localparam logic [5:0] FUNCT6_VWXUNARY0 = 6'b010000;
  localparam logic [5:0] FUNCT6_VMUNARY0  = 6'b010100;

  localparam logic [4:0] VS1_VFIRST = 5'b10001;
  localparam logic [4:0] VS1_VMSBF  = 5'b00001;
  localparam logic [4:0] VS1_VMSOF  = 5'b00010;
  localparam logic [4:0] VS1_VMSIF  = 5'b00011;

  typedef logic [VLEN-1:0]         vreg_t;
  typedef logic [VL_WIDTH-1:0]     vl_t;
  typedef logic [VSTART_WIDTH-1:0] vstart_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_ANDN,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ORN,
    OP_NAND,
    OP_NOR,
    OP_XNOR,
    OP_MSBF,
    OP_MSIF,
    OP_MSOF,
    OP_FIRST
  } mask_op_e;

endpackage

// ==== logic/mask_alu_top.sv ====
module mask_alu_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  uop_valid,
  input  logic [2:0]            funct3,
  input  logic [5:0]            funct6,
  input  logic [4:0]            vs1_op,
  input  logic                  vm,
  input  mask_alu_pkg::vl_t     vl,
  input  mask_alu_pkg::vstart_t vstart,
  input  mask_alu_pkg::tag_t    tag,
  input  mask_alu_pkg::vreg_t   vs1_data,
  input  logic                  vs1_valid,
  input  mask_alu_pkg::vreg_t   vs2_data,
  input  logic                  vs2_valid,
  input  mask_alu_pkg::vreg_t   v0_data,
  input  logic                  v0_valid,
  input  mask_alu_pkg::vreg_t   vd_data,
  input  logic                  vd_valid,
  output logic                  result_valid,
  output mask_alu_pkg::tag_t    result_tag,
  output mask_alu_pkg::vreg_t   result_data
);

  mask_alu_pkg::vreg_t logic_result;
  mask_alu_pkg::vreg_t scan_result;

  mask_operand_if op_bus ();

  mask_uop_decode u_decode (
    .uop_valid (uop_valid),
    .funct3    (funct3),
    .funct6    (funct6),
    .vs1_op    (vs1_op),
    .vm        (vm),
    .vl        (vl),
    .vstart    (vstart),
    .tag       (tag),
    .vs1_data  (vs1_data),
    .vs1_valid (vs1_valid),
    .vs2_data  (vs2_data),
    .vs2_valid (vs2_valid),
    .v0_data   (v0_data),
    .v0_valid  (v0_valid),
    .vd_data   (vd_data),
    .vd_valid  (vd_valid),
    .op_bus    (op_bus.decode)
  );

  // both units see the same operands
  mask_logic_unit u_logic (
    .op_bus       (op_bus.exec),
    .logic_result (logic_result)
  );

  mask_scan_unit u_scan (
    .op_bus      (op_bus.exec),
    .scan_result (scan_result)
  );

  mask_result_merge u_merge (
    .clk          (clk),
    .reset        (reset),
    .op_bus       (op_bus.merge),
    .logic_result (logic_result),
    .scan_result  (scan_result),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data)
  );

endmodule

// ==== logic/mask_logic_unit.sv ====
module mask_logic_unit (
  mask_operand_if.exec        op_bus,
  output mask_alu_pkg::vreg_t logic_result
);

  mask_alu_pkg::vreg_t src2;
  mask_alu_pkg::vreg_t src1;
  mask_alu_pkg::vreg_t src1_n;

  assign src2   = op_bus.src2;
  assign src1   = op_bus.src1;
  // complemented vs1 for andn and orn
  assign src1_n = ~op_bus.src1;

  always_comb begin
    case (op_bus.op)
      mask_alu_pkg::OP_ANDN: logic_result = src2 & src1_n;
      mask_alu_pkg::OP_AND:  logic_result = src2 & src1;
      mask_alu_pkg::OP_OR:   logic_result = src2 | src1;
      mask_alu_pkg::OP_XOR:  logic_result = src2 ^ src1;
      mask_alu_pkg::OP_ORN:  logic_result = src2 | src1_n;
      mask_alu_pkg::OP_NAND: logic_result = ~(src2 & src1);
      mask_alu_pkg::OP_NOR:  logic_result = ~(src2 | src1);
      mask_alu_pkg::OP_XNOR: logic_result = ~(src2 ^ src1);
      default:               logic_result = '0;
    endcase
  end

endmodule

// ==== logic/mask_operand_if.sv ====
interface mask_operand_if;

  logic                   valid;
  mask_alu_pkg::mask_op_e op;
  mask_alu_pkg::vreg_t    src2;
  mask_alu_pkg::vreg_t    src1;
  mask_alu_pkg::vreg_t    v0;
  mask_alu_pkg::vreg_t    vd;
  mask_alu_pkg::vstart_t  vstart;
  logic                   vm;
  mask_alu_pkg::tag_t     tag;

  modport decode (
    output valid, op, src2, src1, v0, vd, vstart, vm, tag
  );

  modport exec (input op, src2, src1);

  modport merge (input valid, op, v0, vd, vstart, vm, tag);

endinterface

// ==== logic/mask_result_merge.sv ====
module mask_result_merge (
  input  logic                clk,
  input  logic                reset,
  mask_operand_if.merge       op_bus,
  input  mask_alu_pkg::vreg_t logic_result,
  input  mask_alu_pkg::vreg_t scan_result,
  output logic                result_valid,
  output mask_alu_pkg::tag_t  result_tag,
  output mask_alu_pkg::vreg_t result_data
);

  logic                is_logic;
  mask_alu_pkg::vreg_t prestart;
  mask_alu_pkg::vreg_t merged;

  always_comb begin
    case (op_bus.op)
      mask_alu_pkg::OP_ANDN, mask_alu_pkg::OP_AND, mask_alu_pkg::OP_OR,
      mask_alu_pkg::OP_XOR, mask_alu_pkg::OP_ORN, mask_alu_pkg::OP_NAND,
      mask_alu_pkg::OP_NOR, mask_alu_pkg::OP_XNOR: is_logic = 1'b1;
      default:                                     is_logic = 1'b0;
    endcase
  end

  // bits below vstart
  always_comb begin
    for (int i = 0; i < mask_alu_pkg::VLEN; i++) begin
      prestart[i] = (i < op_bus.vstart);
    end
  end

  always_comb begin
    if (is_logic)
      merged = (op_bus.vd & prestart) | (logic_result & ~prestart);
    else if (op_bus.vm || op_bus.op == mask_alu_pkg::OP_FIRST)
      merged = scan_result;
    else
      // masked-off elements keep the old destination
      merged = (scan_result & op_bus.v0) | (op_bus.vd & ~op_bus.v0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= op_bus.valid;
    end
  end

  always_ff @(posedge clk) begin
    result_tag  <= op_bus.tag;
    result_data <= merged;
  end

endmodule

// ==== logic/mask_scan_unit.sv ====
module mask_scan_unit (
  mask_operand_if.exec        op_bus,
  output mask_alu_pkg::vreg_t scan_result
);

  mask_alu_pkg::vreg_t                     src2;
  mask_alu_pkg::vreg_t                     src2_sub1;
  mask_alu_pkg::vreg_t                     first_only;
  mask_alu_pkg::vreg_t                     upto_first;
  logic                                    src_zero;
  logic [$clog2(mask_alu_pkg::VLEN)-1:0]   first_idx;

  assign src2       = op_bus.src2;
  assign src2_sub1  = src2 - 1'b1;
  assign src_zero   = (src2 == '0);
  // lowest set bit only
  assign first_only = src2 & ~src2_sub1;
  // all ones up to the lowest set bit, all ones on a zero source too
  assign upto_first = src2 ^ src2_sub1;

  // one-hot to index
  always_comb begin
    first_idx = '0;
    for (int i = 0; i < mask_alu_pkg::VLEN; i++) begin
      if (first_only[i])
        first_idx = $bits(first_idx)'(i);
    end
  end

  always_comb begin
    scan_result = '0;
    case (op_bus.op)
      mask_alu_pkg::OP_MSBF: scan_result = src_zero ? '1 : (upto_first >> 1);
      mask_alu_pkg::OP_MSIF: scan_result = upto_first;
      mask_alu_pkg::OP_MSOF: scan_result = first_only;
      mask_alu_pkg::OP_FIRST: begin
        if (src_zero)
          scan_result = '1;
        else
          scan_result[$bits(first_idx)-1:0] = first_idx;
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/mask_uop_decode.sv ====
module mask_uop_decode (
  input  logic                  uop_valid,
  input  logic [2:0]            funct3,
  input  logic [5:0]            funct6,
  input  logic [4:0]            vs1_op,
  input  logic                  vm,
  input  mask_alu_pkg::vl_t     vl,
  input  mask_alu_pkg::vstart_t vstart,
  input  mask_alu_pkg::tag_t    tag,
  input  mask_alu_pkg::vreg_t   vs1_data,
  input  logic                  vs1_valid,
  input  mask_alu_pkg::vreg_t   vs2_data,
  input  logic                  vs2_valid,
  input  mask_alu_pkg::vreg_t   v0_data,
  input  logic                  v0_valid,
  input  mask_alu_pkg::vreg_t   vd_data,
  input  logic                  vd_valid,
  mask_operand_if.decode        op_bus
);

  mask_alu_pkg::mask_op_e op;
  mask_alu_pkg::vreg_t    tail_mask;
  mask_alu_pkg::vreg_t    src2;
  mask_alu_pkg::vreg_t    src1;
  logic                   ready;

  // opcode fields to op
  always_comb begin
    op = mask_alu_pkg::OP_NONE;
    if (funct3 == mask_alu_pkg::FUNCT3_OPMVV) begin
      case (funct6)
        mask_alu_pkg::FUNCT6_VMANDN: op = mask_alu_pkg::OP_ANDN;
        mask_alu_pkg::FUNCT6_VMAND:  op = mask_alu_pkg::OP_AND;
        mask_alu_pkg::FUNCT6_VMOR:   op = mask_alu_pkg::OP_OR;
        mask_alu_pkg::FUNCT6_VMXOR:  op = mask_alu_pkg::OP_XOR;
        mask_alu_pkg::FUNCT6_VMORN:  op = mask_alu_pkg::OP_ORN;
        mask_alu_pkg::FUNCT6_VMNAND: op = mask_alu_pkg::OP_NAND;
        mask_alu_pkg::FUNCT6_VMNOR:  op = mask_alu_pkg::OP_NOR;
        mask_alu_pkg::FUNCT6_VMXNOR: op = mask_alu_pkg::OP_XNOR;
        mask_alu_pkg::FUNCT6_VWXUNARY0: begin
          if (vs1_op == mask_alu_pkg::VS1_VFIRST)
            op = mask_alu_pkg::OP_FIRST;
        end
        mask_alu_pkg::FUNCT6_VMUNARY0: begin
          case (vs1_op)
            mask_alu_pkg::VS1_VMSBF: op = mask_alu_pkg::OP_MSBF;
            mask_alu_pkg::VS1_VMSIF: op = mask_alu_pkg::OP_MSIF;
            mask_alu_pkg::VS1_VMSOF: op = mask_alu_pkg::OP_MSOF;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // elements below vl
  always_comb begin
    for (int i = 0; i < mask_alu_pkg::VLEN; i++) begin
      tail_mask[i] = (i < vl);
    end
  end

  // operand readiness and source preparation
  always_comb begin
    ready = 1'b0;
    src2  = '0;
    src1  = '0;
    case (op)
      mask_alu_pkg::OP_ANDN, mask_alu_pkg::OP_AND, mask_alu_pkg::OP_OR,
      mask_alu_pkg::OP_XOR, mask_alu_pkg::OP_ORN, mask_alu_pkg::OP_NAND,
      mask_alu_pkg::OP_NOR, mask_alu_pkg::OP_XNOR: begin
        ready = vs1_valid & vs2_valid & vd_valid & vm;
        src2  = vs2_data;
        src1  = vs1_data;
      end
      mask_alu_pkg::OP_FIRST: begin
        ready = !vs1_valid && vs2_valid && (vm || v0_valid);
        src2  = vm ? (vs2_data & tail_mask) : (vs2_data & tail_mask & v0_data);
      end
      mask_alu_pkg::OP_MSBF, mask_alu_pkg::OP_MSIF, mask_alu_pkg::OP_MSOF: begin
        ready = !vs1_valid && vs2_valid && (vm || (vd_valid && v0_valid));
        src2  = vm ? vs2_data : (vs2_data & v0_data);
      end
      default: ;
    endcase
  end

  assign op_bus.valid  = uop_valid & ready;
  assign op_bus.op     = op;
  assign op_bus.src2   = src2;
  assign op_bus.src1   = src1;
  assign op_bus.v0     = v0_data;
  assign op_bus.vd     = vd_data;
  assign op_bus.vstart = vstart;
  assign op_bus.vm     = vm;
  assign op_bus.tag    = tag;

endmodule

// ==== verif/mask_alu_checker.sv ====
module mask_alu_checker (
  input logic clk,
  input logic reset,
  input logic uop_valid,
  input logic result_valid
);

  int assert_failures = 0;

  valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(result_valid))
    else begin
      $error("result_valid is unknown after reset");
      assert_failures++;
    end

  // first cycle out of reset
  valid_low_after_reset: assert property (@(posedge clk) reset |=> !result_valid)
    else begin
      $error("result_valid high in the cycle after reset");
      assert_failures++;
    end

  valid_follows_uop: assert property (
    @(posedge clk) disable iff (reset) result_valid |-> $past(uop_valid))
    else begin
      $error("result_valid without uop_valid one cycle earlier");
      assert_failures++;
    end

endmodule

bind mask_alu_top mask_alu_checker u_checker (
  .clk          (clk),
  .reset        (reset),
  .uop_valid    (uop_valid),
  .result_valid (result_valid)
);

// ==== verif/mask_alu_tb.sv ====
module mask_alu_tb;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 3;
  localparam int          DRIVE_DELAY  = 2;
  localparam logic [31:0] SEED         = 32'h8b17_b732;
  localparam int          N_LOGIC      = 40;
  localparam int          N_SCAN       = 36;
  localparam int          N_FIRST      = 30;
  localparam int          N_UNREADY    = 11;
  localparam int          N_B2B        = 16;
  // reset cycles and the idle drain after each test
  localparam int          N_OVERHEAD   = 20;
  localparam int          TOTAL_UOPS   = N_LOGIC + N_SCAN + N_FIRST + N_UNREADY + N_B2B
                                         + N_OVERHEAD;

  typedef struct {
    logic                  uop_valid, vm, vs1_valid, vs2_valid, v0_valid, vd_valid;
    logic [2:0]            funct3;
    logic [5:0]            funct6;
    logic [4:0]            vs1_op;
    mask_alu_pkg::vl_t     vl;
    mask_alu_pkg::vstart_t vstart;
    mask_alu_pkg::tag_t    tag;
    mask_alu_pkg::vreg_t   vs1_data, vs2_data, v0_data, vd_data;
  } uop_t;

  typedef struct {
    logic                valid;
    mask_alu_pkg::tag_t  tag;
    mask_alu_pkg::vreg_t data;
  } result_t;

  logic                  clk, reset, uop_valid, vm, vs1_valid, vs2_valid, v0_valid, vd_valid;
  logic                  result_valid;
  logic [2:0]            funct3;
  logic [5:0]            funct6;
  logic [4:0]            vs1_op;
  mask_alu_pkg::vl_t     vl;
  mask_alu_pkg::vstart_t vstart;
  mask_alu_pkg::tag_t    tag, result_tag, next_tag;
  mask_alu_pkg::vreg_t   vs1_data, vs2_data, v0_data, vd_data, result_data;

  result_t exp_q[$];
  int      errors, checks, tests_passed, tests_failed, test_start_errors;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  mask_alu_top DUT (.*);

  function automatic mask_alu_pkg::vreg_t rand_vreg();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // kind 0 logical, 1 vmsbf/vmsif/vmsof, 2 vfirst; all operands ready
  function automatic uop_t random_uop(input int kind, input int sub);
    uop_t u;
    u.uop_valid = 1'b1;
    u.funct3    = mask_alu_pkg::FUNCT3_OPMVV;
    u.vm        = 1'b1;
    u.vl        = mask_alu_pkg::vl_t'($urandom_range(0, mask_alu_pkg::VLEN));
    u.vstart    = mask_alu_pkg::vstart_t'($urandom);
    u.tag       = '0;
    u.vs1_data  = rand_vreg();
    // sparse source so the lowest set bit moves around
    u.vs2_data  = rand_vreg() & (rand_vreg() << $urandom_range(0, 120));
    u.v0_data   = rand_vreg();
    u.vd_data   = rand_vreg();
    u.vs1_valid = (kind == 0);
    u.vs2_valid = 1'b1;
    u.v0_valid  = 1'b1;
    u.vd_valid  = 1'b1;
    u.vs1_op    = 5'b0;
    case (kind)
      0: u.funct6 = mask_alu_pkg::FUNCT6_VMANDN + 6'(sub);
      1: begin
        u.funct6 = mask_alu_pkg::FUNCT6_VMUNARY0;
        u.vs1_op = (sub == 0) ? mask_alu_pkg::VS1_VMSBF :
                   (sub == 1) ? mask_alu_pkg::VS1_VMSIF : mask_alu_pkg::VS1_VMSOF;
      end
      default: begin
        u.funct6 = mask_alu_pkg::FUNCT6_VWXUNARY0;
        u.vs1_op = mask_alu_pkg::VS1_VFIRST;
      end
    endcase
    return u;
  endfunction

  function automatic result_t expected_result(input uop_t u);
    result_t                r;
    mask_alu_pkg::mask_op_e op;
    logic                   ready;
    logic                   a, b;
    int                     first;
    r.tag  = u.tag;
    r.data = '0;
    op     = mask_alu_pkg::OP_NONE;
    ready  = 1'b0;
    first  = -1;
    if (u.funct3 == mask_alu_pkg::FUNCT3_OPMVV) begin
      if (u.funct6[5:3] == 3'b011)
        op = mask_alu_pkg::mask_op_e'(4'(u.funct6[2:0]) + 4'd1);
      else if (u.funct6 == mask_alu_pkg::FUNCT6_VWXUNARY0 && u.vs1_op == mask_alu_pkg::VS1_VFIRST)
        op = mask_alu_pkg::OP_FIRST;
      else if (u.funct6 == mask_alu_pkg::FUNCT6_VMUNARY0 && u.vs1_op == mask_alu_pkg::VS1_VMSBF)
        op = mask_alu_pkg::OP_MSBF;
      else if (u.funct6 == mask_alu_pkg::FUNCT6_VMUNARY0 && u.vs1_op == mask_alu_pkg::VS1_VMSIF)
        op = mask_alu_pkg::OP_MSIF;
      else if (u.funct6 == mask_alu_pkg::FUNCT6_VMUNARY0 && u.vs1_op == mask_alu_pkg::VS1_VMSOF)
        op = mask_alu_pkg::OP_MSOF;
    end
    if (op >= mask_alu_pkg::OP_ANDN && op <= mask_alu_pkg::OP_XNOR) begin
      ready = u.vs1_valid && u.vs2_valid && u.vd_valid && u.vm;
      for (int i = 0; i < mask_alu_pkg::VLEN; i++) begin
        a = u.vs2_data[i];
        b = u.vs1_data[i];
        case (op)
          mask_alu_pkg::OP_ANDN: r.data[i] = a & ~b;
          mask_alu_pkg::OP_AND:  r.data[i] = a & b;
          mask_alu_pkg::OP_OR:   r.data[i] = a | b;
          mask_alu_pkg::OP_XOR:  r.data[i] = a ^ b;
          mask_alu_pkg::OP_ORN:  r.data[i] = a | ~b;
          mask_alu_pkg::OP_NAND: r.data[i] = ~(a & b);
          mask_alu_pkg::OP_NOR:  r.data[i] = ~(a | b);
          default:               r.data[i] = ~(a ^ b);
        endcase
        if (i < u.vstart)
          r.data[i] = u.vd_data[i];
      end
    end else if (op != mask_alu_pkg::OP_NONE) begin
      // lowest active bit, vl only limits vfirst
      for (int i = mask_alu_pkg::VLEN - 1; i >= 0; i--) begin
        if (u.vs2_data[i] && (u.vm || u.v0_data[i]) && (op != mask_alu_pkg::OP_FIRST || i < u.vl))
          first = i;
      end
      if (op == mask_alu_pkg::OP_FIRST) begin
        ready  = !u.vs1_valid && u.vs2_valid && (u.vm || u.v0_valid);
        r.data = (first < 0) ? '1 : mask_alu_pkg::vreg_t'(first);
      end else begin
        ready = !u.vs1_valid && u.vs2_valid && (u.vm || (u.vd_valid && u.v0_valid));
        for (int i = 0; i < mask_alu_pkg::VLEN; i++) begin
          case (op)
            mask_alu_pkg::OP_MSBF: r.data[i] = (first < 0) || (i < first);
            mask_alu_pkg::OP_MSIF: r.data[i] = (first < 0) || (i <= first);
            default:               r.data[i] = (i == first);
          endcase
          if (!u.vm && !u.v0_data[i])
            r.data[i] = u.vd_data[i];
        end
      end
    end
    r.valid = u.uop_valid && ready;
    return r;
  endfunction

  task automatic apply_inputs(input uop_t u);
    uop_valid = u.uop_valid;
    funct3    = u.funct3;
    funct6    = u.funct6;
    vs1_op    = u.vs1_op;
    vm        = u.vm;
    vl        = u.vl;
    vstart    = u.vstart;
    tag       = u.tag;
    vs1_data  = u.vs1_data;
    vs1_valid = u.vs1_valid;
    vs2_data  = u.vs2_data;
    vs2_valid = u.vs2_valid;
    v0_data   = u.v0_data;
    v0_valid  = u.v0_valid;
    vd_data   = u.vd_data;
    vd_valid  = u.vd_valid;
  endtask

  task automatic drive_uop(input uop_t u);
    result_t r;
    @(posedge clk);
    #DRIVE_DELAY;
    u.tag    = next_tag;
    next_tag = next_tag + 1'b1;
    apply_inputs(u);
    r = expected_result(u);
    // reset still held at the capturing edge
    r.valid = r.valid && !reset;
    exp_q.push_back(r);
  endtask

  task automatic check_valid(input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED result_valid: got %h, expected %h", actual, expected);
    end
  endtask

  task automatic check_tag(input mask_alu_pkg::tag_t actual, input mask_alu_pkg::tag_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED result_tag: got %h, expected %h", actual, expected);
    end
  endtask

  task automatic check_data(input mask_alu_pkg::vreg_t actual,
                            input mask_alu_pkg::vreg_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED result_data: got %h, expected %h", actual, expected);
    end
  endtask

  task automatic finish_test(input string name);
    uop_t idle;
    idle = '{default: '0};
    drive_uop(idle);
    wait (exp_q.size() == 0);
    @(negedge clk);
    #1;
    if (errors == test_start_errors) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // one result per cycle, checked mid-cycle against the oldest driven uop
  initial begin : compare
    result_t exp;
    forever begin
      @(posedge clk);
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        @(negedge clk);
        check_valid(result_valid, exp.valid);
        if (exp.valid) begin
          check_tag(result_tag, exp.tag);
          check_data(result_data, exp.data);
        end
      end
    end
  end

  initial begin : watchdog
    #((TOTAL_UOPS + 50) * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", TOTAL_UOPS + 50);
    $display("** FAIL **");
    $finish;
  end

  initial begin : stimulus
    uop_t u;
    void'($urandom(SEED));
    u = '{default: '0};
    apply_inputs(u);
    next_tag = '0;

    do begin
      drive_uop(random_uop(0, $urandom_range(0, 7)));
    end while (reset);
    finish_test("reset");

    repeat (N_LOGIC) drive_uop(random_uop(0, $urandom_range(0, 7)));
    finish_test("logical ops");

    for (int k = 0; k < N_SCAN; k++) begin
      u    = random_uop(1, k % 3);
      u.vm = ((k / 3) % 2) == 0;
      if (k < 6)
        u.vs2_data = '0;
      drive_uop(u);
    end
    finish_test("vmsbf/vmsif/vmsof");

    for (int k = 0; k < N_FIRST; k++) begin
      u    = random_uop(2, 0);
      u.vm = k[0];
      if (k == 0)
        u.vl = '0;
      if (k == 1) begin
        // set bits only at and above vl
        u.vs2_data = ~mask_alu_pkg::vreg_t'(0) << 64;
        u.vl       = 8'd64;
      end
      drive_uop(u);
    end
    finish_test("vfirst");

    for (int k = 0; k < N_UNREADY; k++) begin
      u = random_uop(k % 3, 0);
      case (k)
        0: u.vs2_valid = 1'b0;
        1: u.vs1_valid = 1'b1;
        2: u.vs2_valid = 1'b0;
        3: u.vm = 1'b0;
        4: begin
          u.vm       = 1'b0;
          u.vd_valid = 1'b0;
        end
        5: begin
          u.vm       = 1'b0;
          u.v0_valid = 1'b0;
        end
        6: u.funct3 = 3'b000;
        7: u.vs1_op = 5'b00000;
        // vcpop encoding, not supported here
        8: u.vs1_op = 5'b10000;
        9: u.funct6 = 6'b000000;
        default: u.uop_valid = 1'b0;
      endcase
      drive_uop(u);
    end
    finish_test("unready and unsupported");

    for (int k = 0; k < N_B2B; k++) begin
      drive_uop(random_uop(k % 3, $urandom_range(0, 2)));
    end
    finish_test("back-to-back");

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_passed, tests_failed, checks, errors, DUT.u_checker.assert_failures);
    if (errors == 0 && tests_failed == 0 && DUT.u_checker.assert_failures == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // released just after an edge, ahead of the stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule
